//--- Bender.yml
package:
  name: mxu

sources:
  - hdl/mxu_pkg.sv
  - hdl/apb_csr.sv
  - hdl/weight_memory.sv
  - hdl/sync_fifo.sv
  - hdl/systolic_mxu.sv
  - hdl/control_unit.sv
  - hdl/mxu_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/mxu_tb.sv

//--- flist.f
hdl/mxu_pkg.sv
hdl/apb_csr.sv
hdl/weight_memory.sv
hdl/sync_fifo.sv
hdl/systolic_mxu.sv
hdl/control_unit.sv
hdl/mxu_top.sv
tb/tb_clock_gen.sv
tb/mxu_tb.sv

//--- hdl/apb_csr.sv
`timescale 1ns/1ps

module apb_csr (
        input  logic                            clk,
        input  logic                            reset,
        input  mxu_pkg::apb_req_t               apb_req,
        output mxu_pkg::apb_rsp_t               apb_rsp,
        output mxu_pkg::job_cfg_t               cfg,
        input  mxu_pkg::job_status_t            status,
        output logic                            wm_we,
        output logic [1:0]                      wm_waddr,
        output mxu_pkg::act_vec_t               wm_wdata,
        output logic                            in_push,
        output mxu_pkg::act_vec_t               in_data,
        input  logic                            in_full,
        input  mxu_pkg::acc_vec_t               out_head,
        input  logic                            out_empty,
        output logic                            out_pop,
        input  logic [mxu_pkg::level_width-1:0] in_level,
        input  logic [mxu_pkg::level_width-1:0] out_level
);

        logic       wr;
        logic       rd;
        logic       mapped;
        logic       is_weight;
        logic       enable;
        logic [7:0] length;
        logic       done_flag;
        logic [1:0] start_hold;

        // access phase only, no wait states
        assign wr = apb_req.psel & apb_req.penable & apb_req.pwrite;
        assign rd = apb_req.psel & apb_req.penable & ~apb_req.pwrite;

        assign is_weight = apb_req.paddr inside {mxu_pkg::reg_weight0, mxu_pkg::reg_weight1,
                                                 mxu_pkg::reg_weight2};
        assign mapped = is_weight || apb_req.paddr inside {mxu_pkg::reg_ctrl,
                        mxu_pkg::reg_status, mxu_pkg::reg_length, mxu_pkg::reg_in_data,
                        mxu_pkg::reg_out0, mxu_pkg::reg_out1, mxu_pkg::reg_out2,
                        mxu_pkg::reg_level};

        // weights only change while the controller sits in idle
        assign wm_we    = wr && is_weight && status.idle;
        assign wm_waddr = apb_req.paddr[3:2];
        assign wm_wdata = apb_req.pwdata[23:0];

        assign in_push = wr && apb_req.paddr == mxu_pkg::reg_in_data && !in_full;
        assign in_data = apb_req.pwdata[23:0];
        assign out_pop = rd && apb_req.paddr == mxu_pkg::reg_out2 && !out_empty;

        always_ff @(posedge clk) begin
                if (!reset) begin
                        enable     <= 1'b0;
                        length     <= 8'd0;
                        done_flag  <= 1'b0;
                        start_hold <= 2'd0;
                end else begin
                        if (start_hold != 2'd0)
                                start_hold <= start_hold - 2'd1;
                        if (status.done)
                                done_flag <= 1'b1;
                        if (wr && apb_req.paddr == mxu_pkg::reg_ctrl) begin
                                enable <= apb_req.pwdata[1];
                                // start stays up three cycles for the confirmation
                                if (apb_req.pwdata[0]) begin
                                        start_hold <= 2'd3;
                                        done_flag  <= 1'b0;
                                end
                        end
                        if (wr && apb_req.paddr == mxu_pkg::reg_length)
                                length <= apb_req.pwdata[7:0];
                end
        end

        assign cfg = '{enable: enable, start: start_hold != 2'd0, length: length};

        always_comb begin
                apb_rsp.pready = 1'b1;
                case (apb_req.paddr)
                mxu_pkg::reg_ctrl:   apb_rsp.prdata = {30'd0, enable, 1'b0};
                mxu_pkg::reg_status: apb_rsp.prdata = {29'd0, done_flag, status.busy, status.idle};
                mxu_pkg::reg_length: apb_rsp.prdata = {24'd0, length};
                mxu_pkg::reg_out0:   apb_rsp.prdata = 32'(out_head.y0);
                mxu_pkg::reg_out1:   apb_rsp.prdata = 32'(out_head.y1);
                mxu_pkg::reg_out2:   apb_rsp.prdata = 32'(out_head.y2);
                mxu_pkg::reg_level:  apb_rsp.prdata = {20'd0, out_level, 4'd0, in_level};
                default:             apb_rsp.prdata = 32'd0;
                endcase
                apb_rsp.pslverr = (wr | rd) & (!mapped
                        || (wr && apb_req.paddr == mxu_pkg::reg_in_data && in_full)
                        || (rd && apb_req.paddr == mxu_pkg::reg_out2 && out_empty)
                        || (wr && is_weight && !status.idle));
        end

endmodule

//--- hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
        input  logic                            clk,
        input  logic                            reset,
        input  mxu_pkg::job_cfg_t               cfg,
        output mxu_pkg::job_status_t            status,
        output logic                            wm_re,
        output logic [1:0]                      wm_raddr,
        output logic [mxu_pkg::mxu_dim-1:0]     load_col,
        output logic                            issue,
        input  logic                            in_empty,
        input  logic [mxu_pkg::level_width-1:0] out_level,
        input  logic                            out_valid,
        output logic                            fifo_flush
);

        mxu_pkg::ctrl_state_e             state;
        // start confirmation count, then weight column count
        logic [1:0]                       step;
        logic [7:0]                       issued;
        logic [mxu_pkg::level_width-1:0]  in_flight;
        logic                             credit;

        // room left in the output fifo for everything in flight
        assign credit = (out_level + in_flight) < mxu_pkg::out_fifo_depth;

        assign issue = state == mxu_pkg::compute && !in_empty && credit
                       && issued < cfg.length;

        // read column k, latch it one cycle later
        assign wm_re    = state == mxu_pkg::load_weights && step != 2'd3;
        assign wm_raddr = step;
        assign load_col = (state == mxu_pkg::load_weights && step != 2'd0)
                          ? 3'b001 << (step - 2'd1) : 3'b000;

        assign status = '{idle:  state == mxu_pkg::idle,
                          busy:  state != mxu_pkg::idle && state != mxu_pkg::power_up,
                          done:  state == mxu_pkg::done,
                          state: state};

        always_ff @(posedge clk) begin
                if (!reset) begin
                        state      <= mxu_pkg::power_up;
                        step       <= 2'd0;
                        issued     <= 8'd0;
                        in_flight  <= '0;
                        fifo_flush <= 1'b0;
                end else begin
                        fifo_flush <= 1'b0;
                        if (issue && !out_valid)
                                in_flight <= in_flight + 1'b1;
                        else if (out_valid && !issue)
                                in_flight <= in_flight - 1'b1;
                        if (issue)
                                issued <= issued + 8'd1;

                        case (state)
                        mxu_pkg::power_up: begin
                                fifo_flush <= 1'b1;
                                state      <= mxu_pkg::idle;
                        end
                        mxu_pkg::idle: begin
                                step   <= 2'd0;
                                issued <= 8'd0;
                                if (cfg.start && cfg.enable)
                                        state <= mxu_pkg::start_sync;
                        end
                        mxu_pkg::start_sync: begin
                                // start must stay up for the whole sequence
                                if (!cfg.start) begin
                                        state <= mxu_pkg::idle;
                                end else if (step == 2'd1) begin
                                        step  <= 2'd0;
                                        state <= mxu_pkg::load_weights;
                                end else begin
                                        step <= step + 2'd1;
                                end
                        end
                        mxu_pkg::load_weights: begin
                                step <= step + 2'd1;
                                if (step == 2'd3)
                                        state <= mxu_pkg::compute;
                        end
                        mxu_pkg::compute: begin
                                if (issued == cfg.length)
                                        state <= mxu_pkg::drain;
                        end
                        mxu_pkg::drain: begin
                                if (in_flight == '0)
                                        state <= mxu_pkg::done;
                        end
                        mxu_pkg::done: begin
                                state <= mxu_pkg::idle;
                        end
                        default: begin
                                state <= mxu_pkg::power_up;
                        end
                        endcase
                end
        end

endmodule

//--- hdl/mxu_pkg.sv
package mxu_pkg;

        localparam int act_width      = 8;
        localparam int acc_width      = 18;
        localparam int mxu_dim        = 3;
        localparam int in_fifo_depth  = 8;
        localparam int out_fifo_depth = 8;
        localparam int pipe_latency   = 3;
        localparam int level_width    = 4;

        //////////////////////////////////////////////////
        // apb register byte offsets
        localparam logic [7:0] reg_ctrl    = 8'h00;
        localparam logic [7:0] reg_status  = 8'h04;
        localparam logic [7:0] reg_length  = 8'h08;
        localparam logic [7:0] reg_in_data = 8'h0C;
        localparam logic [7:0] reg_weight0 = 8'h10;
        localparam logic [7:0] reg_weight1 = 8'h14;
        localparam logic [7:0] reg_weight2 = 8'h18;
        localparam logic [7:0] reg_out0    = 8'h20;
        localparam logic [7:0] reg_out1    = 8'h24;
        localparam logic [7:0] reg_out2    = 8'h28;
        localparam logic [7:0] reg_level   = 8'h2C;

        typedef enum logic [2:0] {
                power_up, idle, start_sync, load_weights, compute, drain, done
        } ctrl_state_e;

        // one input vector, also one weight column (w2k, w1k, w0k)
        typedef struct packed {
                logic signed [act_width-1:0] x2;
                logic signed [act_width-1:0] x1;
                logic signed [act_width-1:0] x0;
        } act_vec_t;

        typedef struct packed {
                logic signed [acc_width-1:0] y2;
                logic signed [acc_width-1:0] y1;
                logic signed [acc_width-1:0] y0;
        } acc_vec_t;

        typedef struct packed {
                logic        psel;
                logic        penable;
                logic        pwrite;
                logic [7:0]  paddr;
                logic [31:0] pwdata;
        } apb_req_t;

        typedef struct packed {
                logic [31:0] prdata;
                logic        pready;
                logic        pslverr;
        } apb_rsp_t;

        typedef struct packed {
                logic       enable;
                logic       start;
                logic [7:0] length;
        } job_cfg_t;

        typedef struct packed {
                logic        idle;
                logic        busy;
                logic        done;
                ctrl_state_e state;
        } job_status_t;

endpackage

//--- hdl/mxu_top.sv
`timescale 1ns/1ps

module mxu_top (
        input  logic              clk,
        input  logic              reset,
        input  mxu_pkg::apb_req_t apb_req,
        output mxu_pkg::apb_rsp_t apb_rsp
);

        mxu_pkg::job_cfg_t               cfg;
        mxu_pkg::job_status_t            status;
        logic                            wm_we;
        logic [1:0]                      wm_waddr;
        mxu_pkg::act_vec_t               wm_wdata;
        logic                            wm_re;
        logic [1:0]                      wm_raddr;
        mxu_pkg::act_vec_t               wm_rdata;
        logic                            in_push;
        mxu_pkg::act_vec_t               in_data;
        mxu_pkg::act_vec_t               in_head;
        logic                            in_full;
        logic                            in_empty;
        logic [mxu_pkg::level_width-1:0] in_level;
        mxu_pkg::acc_vec_t               out_head;
        mxu_pkg::acc_vec_t               acc_y;
        logic                            out_valid;
        logic                            out_pop;
        logic                            out_empty;
        logic [mxu_pkg::level_width-1:0] out_level;
        logic [mxu_pkg::mxu_dim-1:0]     load_col;
        logic                            issue;
        logic                            fifo_flush;

        apb_csr csr0 (
                .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
                .cfg(cfg), .status(status),
                .wm_we(wm_we), .wm_waddr(wm_waddr), .wm_wdata(wm_wdata),
                .in_push(in_push), .in_data(in_data), .in_full(in_full),
                .out_head(out_head), .out_empty(out_empty), .out_pop(out_pop),
                .in_level(in_level), .out_level(out_level)
        );

        weight_memory wmem0 (
                .clk(clk), .reset(reset), .we(wm_we), .waddr(wm_waddr), .wdata(wm_wdata),
                .re(wm_re), .raddr(wm_raddr), .rdata(wm_rdata)
        );

        //////////////////////////////////////////////////
        // input and output queues
        sync_fifo #(.width($bits(mxu_pkg::act_vec_t)), .depth(mxu_pkg::in_fifo_depth)) in_fifo (
                .clk(clk), .reset(reset), .flush(fifo_flush),
                .push(in_push), .wdata(in_data), .pop(issue), .rdata(in_head),
                .full(in_full), .empty(in_empty), .level(in_level)
        );

        sync_fifo #(.width($bits(mxu_pkg::acc_vec_t)), .depth(mxu_pkg::out_fifo_depth)) out_fifo (
                .clk(clk), .reset(reset), .flush(fifo_flush),
                .push(out_valid), .wdata(acc_y), .pop(out_pop), .rdata(out_head),
                .full(), .empty(out_empty), .level(out_level)
        );

        systolic_mxu mxu0 (
                .clk(clk), .reset(reset), .load_col(load_col), .wdata(wm_rdata),
                .issue(issue), .x(in_head), .out_valid(out_valid), .y(acc_y)
        );

        control_unit ctrl0 (
                .clk(clk), .reset(reset), .cfg(cfg), .status(status),
                .wm_re(wm_re), .wm_raddr(wm_raddr), .load_col(load_col), .issue(issue),
                .in_empty(in_empty), .out_level(out_level), .out_valid(out_valid),
                .fifo_flush(fifo_flush)
        );

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
        parameter int width = 8,
        parameter int depth = 4
) (
        input  logic                         clk,
        input  logic                         reset,
        input  logic                         flush,
        input  logic                         push,
        input  logic [width-1:0]             wdata,
        input  logic                         pop,
        output logic [width-1:0]             rdata,
        output logic                         full,
        output logic                         empty,
        output logic [$clog2(depth+1)-1:0]   level
);

        logic [width-1:0]         mem [depth];
        logic [$clog2(depth)-1:0] wr_ptr;
        logic [$clog2(depth)-1:0] rd_ptr;
        logic                     do_push;
        logic                     do_pop;

        assign do_push = push && !full;
        assign do_pop  = pop && !empty;
        assign full    = level == depth;
        assign empty   = level == 0;
        // head falls through
        assign rdata   = mem[rd_ptr];

        always_ff @(posedge clk) begin
                if (do_push)
                        mem[wr_ptr] <= wdata;
        end

        always_ff @(posedge clk) begin
                if (!reset || flush) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        level  <= '0;
                end else begin
                        if (do_push)
                                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
                        if (do_push && !do_pop)
                                level <= level + 1'b1;
                        else if (do_pop && !do_push)
                                level <= level - 1'b1;
                end
        end

endmodule

//--- hdl/systolic_mxu.sv
`timescale 1ns/1ps

module systolic_mxu (
        input  logic                        clk,
        input  logic                        reset,
        input  logic [mxu_pkg::mxu_dim-1:0] load_col,
        input  mxu_pkg::act_vec_t           wdata,
        input  logic                        issue,
        input  mxu_pkg::act_vec_t           x,
        output logic                        out_valid,
        output mxu_pkg::acc_vec_t           y
);

        mxu_pkg::act_vec_t                  w_col [mxu_pkg::mxu_dim];
        logic [mxu_pkg::pipe_latency-1:0]   vld;
        mxu_pkg::acc_vec_t                  s0;
        mxu_pkg::acc_vec_t                  s1;
        mxu_pkg::acc_vec_t                  s2;
        logic signed [mxu_pkg::act_width-1:0] x1_d1;
        logic signed [mxu_pkg::act_width-1:0] x2_d1;
        logic signed [mxu_pkg::act_width-1:0] x2_d2;

        // partial sums plus one weight column times one activation
        function automatic mxu_pkg::acc_vec_t mac(input mxu_pkg::acc_vec_t acc,
                                                  input mxu_pkg::act_vec_t w,
                                                  input logic signed [mxu_pkg::act_width-1:0] a);
                mxu_pkg::acc_vec_t r;
                r.y0 = acc.y0 + w.x0 * a;
                r.y1 = acc.y1 + w.x1 * a;
                r.y2 = acc.y2 + w.x2 * a;
                return r;
        endfunction

        // stationary weights
        always_ff @(posedge clk) begin
                for (int k = 0; k < mxu_pkg::mxu_dim; k++) begin
                        if (load_col[k])
                                w_col[k] <= wdata;
                end
        end

        always_ff @(posedge clk) begin
                if (!reset)
                        vld <= '0;
                else
                        vld <= {vld[mxu_pkg::pipe_latency-2:0], issue};
        end

        //////////////////////////////////////////////////
        // stage k consumes activation k, later ones ride along
        always_ff @(posedge clk) begin
                s0    <= mac('0, w_col[0], x.x0);
                x1_d1 <= x.x1;
                x2_d1 <= x.x2;
                s1    <= mac(s0, w_col[1], x1_d1);
                x2_d2 <= x2_d1;
                s2    <= mac(s1, w_col[2], x2_d2);
        end

        assign out_valid = vld[mxu_pkg::pipe_latency-1];
        assign y         = s2;

endmodule

//--- hdl/weight_memory.sv
`timescale 1ns/1ps

module weight_memory (
        input  logic              clk,
        input  logic              reset,
        input  logic              we,
        input  logic [1:0]        waddr,
        input  mxu_pkg::act_vec_t wdata,
        input  logic              re,
        input  logic [1:0]        raddr,
        output mxu_pkg::act_vec_t rdata
);

        // one word per weight column
        mxu_pkg::act_vec_t mem [mxu_pkg::mxu_dim];

        always_ff @(posedge clk) begin
                if (!reset) begin
                        for (int i = 0; i < mxu_pkg::mxu_dim; i++)
                                mem[i] <= '0;
                end else if (we) begin
                        mem[waddr] <= wdata;
                end
        end

        always_ff @(posedge clk) begin
                if (re)
                        rdata <= mem[raddr];
        end

endmodule

//--- tb/mxu_tb.sv
`timescale 1ns/1ps

module mxu_tb;

        localparam int total_vectors = 30;
        localparam int cycle_limit   = 20 * total_vectors + 500;

        logic              clk;
        logic              reset;
        mxu_pkg::apb_req_t apb_req;
        mxu_pkg::apb_rsp_t apb_rsp;
        mxu_pkg::act_vec_t wcol [3];
        mxu_pkg::acc_vec_t exp_q [$];
        mxu_pkg::acc_vec_t got_q [$];
        int                n_expected = 0;
        int                n_got = 0;
        int                n_checked = 0;
        int                cycles = 0;

        tb_clock_gen clkgen0 (.clk(clk), .reset(reset));

        mxu_top dut0 (.clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp));

        //////////////////////////////////////////////////
        // reference model

        function automatic int elem(input mxu_pkg::act_vec_t v, input int i);
                case (i)
                0:       return int'(v.x0);
                1:       return int'(v.x1);
                default: return int'(v.x2);
                endcase
        endfunction

        // y_i = sum over k of w_ik * x_k, column k holds w_ik at element i
        function automatic mxu_pkg::acc_vec_t matvec(input mxu_pkg::act_vec_t w [3],
                                                     input mxu_pkg::act_vec_t x);
                int                s [3];
                mxu_pkg::acc_vec_t r;
                for (int i = 0; i < 3; i++) begin
                        s[i] = 0;
                        for (int k = 0; k < 3; k++)
                                s[i] += elem(w[k], i) * elem(x, k);
                end
                r.y0 = 18'(s[0]);
                r.y1 = 18'(s[1]);
                r.y2 = 18'(s[2]);
                return r;
        endfunction

        //////////////////////////////////////////////////
        // checks

        task automatic stop_run();
                $display("STATUS: FAIL");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_acc(input mxu_pkg::acc_vec_t got, input mxu_pkg::acc_vec_t exp,
                                 input string what);
                if (got !== exp) begin
                        $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                                  input string what);
                if (got !== exp) begin
                        $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_err(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
                        stop_run();
                end
        endtask

        //////////////////////////////////////////////////
        // apb access, setup and access phase on falling edges

        task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                                output logic [31:0] rdata, output logic err);
                @(negedge clk);
                apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
                @(negedge clk);
                apb_req.penable = 1'b1;
                #1;
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
                check_err(apb_rsp.pready, 1'b1, "pready in access phase");
                @(negedge clk);
                apb_req = '0;
        endtask

        task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                                 input logic exp_err);
                logic [31:0] rd;
                logic        err;
                apb_xfer(1'b1, addr, data, rd, err);
                check_err(err, exp_err, $sformatf("pslverr on write to %h", addr));
        endtask

        task automatic read_reg(input logic [7:0] addr, input logic exp_err,
                                output logic [31:0] data);
                logic err;
                apb_xfer(1'b0, addr, 32'd0, data, err);
                check_err(err, exp_err, $sformatf("pslverr on read of %h", addr));
        endtask

        //////////////////////////////////////////////////
        // job helpers

        function automatic mxu_pkg::act_vec_t rand_vec();
                mxu_pkg::act_vec_t v;
                v = 24'($urandom);
                return v;
        endfunction

        function automatic mxu_pkg::act_vec_t extreme_vec();
                mxu_pkg::act_vec_t v;
                v.x0 = ($urandom & 1) ? 8'h7F : 8'h80;
                v.x1 = ($urandom & 1) ? 8'h7F : 8'h80;
                v.x2 = ($urandom & 1) ? 8'h7F : 8'h80;
                return v;
        endfunction

        task automatic write_weights();
                for (int k = 0; k < 3; k++)
                        write_reg(mxu_pkg::reg_weight0 + 8'(4 * k), {8'h0, wcol[k]}, 1'b0);
        endtask

        task automatic push_vec(input mxu_pkg::act_vec_t x);
                write_reg(mxu_pkg::reg_in_data, {8'h0, x}, 1'b0);
                exp_q.push_back(matvec(wcol, x));
                n_expected++;
        endtask

        task automatic wait_done();
                logic [31:0] st;
                st = '0;
                while (!st[2])
                        read_reg(mxu_pkg::reg_status, 1'b0, st);
        endtask

        // wait for a queued result, read the three sums, pop on the last
        task automatic read_result();
                logic [31:0]       lvl;
                logic [31:0]       w [3];
                mxu_pkg::acc_vec_t r;
                lvl = '0;
                while (lvl[11:8] == 4'd0)
                        read_reg(mxu_pkg::reg_level, 1'b0, lvl);
                for (int k = 0; k < 3; k++) begin
                        read_reg(mxu_pkg::reg_out0 + 8'(4 * k), 1'b0, w[k]);
                        check_word(w[k], {{14{w[k][17]}}, w[k][17:0]}, "result sign extension");
                end
                r.y0 = w[0][17:0];
                r.y1 = w[1][17:0];
                r.y2 = w[2][17:0];
                got_q.push_back(r);
                n_got++;
        endtask

        task automatic run_job(input int n);
                write_reg(mxu_pkg::reg_length, 32'(n), 1'b0);
                write_reg(mxu_pkg::reg_ctrl, 32'h3, 1'b0);
                wait_done();
                repeat (n) read_result();
        endtask

        //////////////////////////////////////////////////
        // result comparison in order of issue
        initial begin
                mxu_pkg::acc_vec_t got;
                forever begin
                        wait (n_got > n_checked);
                        got = got_q.pop_front();
                        if (exp_q.size() == 0) begin
                                $display("the DUT returned a result that was never expected");
                                stop_run();
                        end
                        check_acc(got, exp_q.pop_front(), "matrix-vector result");
                        n_checked++;
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= cycle_limit) begin
                        $display("timeout: the run did not finish in %0d cycles", cycle_limit);
                        stop_run();
                end
        end

        initial begin
                logic [31:0] rd;
                apb_req = '0;
                void'($urandom(32'h1de38de6));
                wait (reset === 1'b1);
                repeat (3) @(negedge clk);

                // idle with both queues empty
                read_reg(mxu_pkg::reg_status, 1'b0, rd);
                check_word(rd, 32'h1, "status after reset");
                read_reg(mxu_pkg::reg_level, 1'b0, rd);
                check_word(rd, 32'h0, "levels after reset");

                // five-vector job
                for (int k = 0; k < 3; k++)
                        wcol[k] = rand_vec();
                write_weights();
                repeat (5) push_vec(rand_vec());
                run_job(5);
                read_reg(mxu_pkg::reg_status, 1'b0, rd);
                check_word(rd, 32'h5, "status after first job");

                // back-pressure, output queue fills and issue pauses
                write_reg(mxu_pkg::reg_length, 32'd12, 1'b0);
                repeat (8) push_vec(rand_vec());
                write_reg(mxu_pkg::reg_ctrl, 32'h3, 1'b0);
                read_reg(mxu_pkg::reg_status, 1'b0, rd);
                check_word(rd, 32'h2, "status after second start");
                rd = '0;
                while (rd[11:8] != 4'd8)
                        read_reg(mxu_pkg::reg_level, 1'b0, rd);
                repeat (10) @(negedge clk);
                read_reg(mxu_pkg::reg_level, 1'b0, rd);
                check_word(rd, 32'h0800, "levels with output queue full");
                repeat (4) push_vec(rand_vec());
                read_reg(mxu_pkg::reg_level, 1'b0, rd);
                check_word(rd, 32'h0804, "levels while stalled");
                repeat (12) read_result();
                wait_done();

                // extreme operands
                for (int k = 0; k < 3; k++) begin
                        wcol[k] = extreme_vec();
                        // row 0 all -128 and row 2 all 127 give the largest sums
                        wcol[k].x0 = 8'h80;
                        wcol[k].x2 = 8'h7F;
                end
                write_weights();
                push_vec(24'h808080);
                push_vec(24'h7F7F7F);
                repeat (2) push_vec(extreme_vec());
                run_job(4);

                // error responses
                write_reg(8'h30, 32'h0, 1'b1);
                read_reg(mxu_pkg::reg_out2, 1'b1, rd);
                repeat (8) push_vec(rand_vec());
                write_reg(mxu_pkg::reg_in_data, 32'h0, 1'b1);
                write_reg(mxu_pkg::reg_length, 32'd8, 1'b0);
                write_reg(mxu_pkg::reg_ctrl, 32'h3, 1'b0);
                write_reg(mxu_pkg::reg_weight0, 32'h0, 1'b1);
                repeat (8) read_result();
                wait_done();

                // start without enable stays idle
                write_reg(mxu_pkg::reg_in_data, {8'h0, rand_vec()}, 1'b0);
                write_reg(mxu_pkg::reg_ctrl, 32'h1, 1'b0);
                repeat (8) @(negedge clk);
                read_reg(mxu_pkg::reg_status, 1'b0, rd);
                check_word(rd, 32'h1, "status after start without enable");
                read_reg(mxu_pkg::reg_level, 1'b0, rd);
                check_word(rd, 32'h0001, "levels after start without enable");

                wait (n_checked == n_expected);
                $display("STATUS: PASS");
                $finish;
        end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
        output logic clk,
        output logic reset
);

        // 40 ns period
        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // active low, held over two rising edges
        initial begin
                reset = 1'b0;
                repeat (2) @(posedge clk);
                @(negedge clk);
                reset = 1'b1;
        end

endmodule
